// ==== source/alu.sv ====
// Integer ALU
// Add, subtract, logic, signed compare, left shift and upper
// immediate load, plus signed overflow for add and subtract

`timescale 1ns/1ps
`default_nettype none

module alu
    import cpu_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            overflow
);

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;

    assign sum  = a + b;    // Wraps mod 2^32
    assign diff = a - b;

    always_comb begin
        overflow = 1'b0;
        case (op)
            ALU_ADD: begin
                result = sum;
                // Same-sign operands, result sign flipped
                overflow = (a[XLEN-1] == b[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
            end
            ALU_SUB: begin
                result = diff;
                // Opposite-sign operands, result sign differs from a
                overflow = (a[XLEN-1] != b[XLEN-1]) && (diff[XLEN-1] != a[XLEN-1]);
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLL: result = a << b[REG_ADDR_W-1:0];   // Only the low 5 bits count
            ALU_LUI: result = {b[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu_pkg.sv ====
// CPU package
// Field widths, instruction encodings, ALU controls and the records
// carried between decode, execute and writeback

`default_nettype none

package cpu_pkg;

    // ========================================================
    // Widths
    // ========================================================
    localparam int XLEN       = 32;   // Data path width
    localparam int REG_ADDR_W = 5;    // Also the shift amount width
    localparam int NUM_REGS   = 32;
    localparam int IMM_W      = 16;

    // ========================================================
    // Instruction encodings
    // ========================================================
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,   // Operation picked by funct
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL     = 6'h00,
        FN_SYSCALL = 6'h0C,
        FN_ADD     = 6'h20,
        FN_SUB     = 6'h22,
        FN_AND     = 6'h24,
        FN_OR      = 6'h25,
        FN_SLT     = 6'h2A
    } funct_e;

    // ALU controls
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        OPB_REG,    // rt value
        OPB_SIMM,   // Sign-extended immediate
        OPB_ZIMM,   // Zero-extended immediate
        OPB_SHAMT   // Shift amount field
    } operand_b_e;

    // ========================================================
    // Stage records
    // ========================================================
    typedef struct packed {
        alu_op_e                alu_op;
        operand_b_e             opb_sel;
        logic                   wen;      // Already low for r0
        logic [REG_ADDR_W-1:0]  waddr;
        logic                   chk_ovf;  // Add/sub family only
        logic                   syscall;
    } ctrl_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [XLEN-1:0]        rs_val;   // After forwarding
        logic [XLEN-1:0]        rt_val;
        logic [IMM_W-1:0]       imm;
        logic [REG_ADDR_W-1:0]  shamt;
    } id_ex_t;

    // One bypass source
    typedef struct packed {
        logic                   wen;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [XLEN-1:0]        data;
    } fwd_t;

    typedef struct packed {
        logic                   valid;
        logic                   wen;
        logic [REG_ADDR_W-1:0]  waddr;
        logic [XLEN-1:0]        data;
        logic                   overflow;
        logic                   syscall;
    } retire_t;

endpackage

`default_nettype wire

// ==== source/decode_stage.sv ====
// Decode stage
// Decodes the strobed instruction, reads rs and rt, picks the newest
// value of each through the bypass network and registers the result
// into the decode/execute record

`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  logic [XLEN-1:0] inst,
    input  fwd_t            ex_fwd,
    input  retire_t         retire,
    output id_ex_t          id_ex
);

    logic [REG_ADDR_W-1:0]  rs;
    logic [REG_ADDR_W-1:0]  rt;
    logic [XLEN-1:0]        rf_rs;      // Raw register file reads
    logic [XLEN-1:0]        rf_rt;
    logic [XLEN-1:0]        rs_fwd;     // After bypass
    logic [XLEN-1:0]        rt_fwd;
    ctrl_t                  ctrl;

    // Decode/execute register
    logic                   valid_q;
    ctrl_t                  ctrl_q;
    logic [XLEN-1:0]        rs_q;
    logic [XLEN-1:0]        rt_q;
    logic [IMM_W-1:0]       imm_q;
    logic [REG_ADDR_W-1:0]  shamt_q;

    assign rs = inst[25:21];
    assign rt = inst[20:16];

    inst_decoder u_dec (
        .inst (inst),
        .ctrl (ctrl)
    );

    register_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .raddr0 (rs),
        .raddr1 (rt),
        .rdata0 (rf_rs),
        .rdata1 (rf_rt),
        .wr     (retire)        // Writeback port
    );

    // ========================================================
    // Bypass, newest producer wins
    // ========================================================
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_val,
        input fwd_t                  ex_src,
        input retire_t               wb_src
    );
        if (addr == '0)
            return '0;
        if (ex_src.wen && ex_src.waddr == addr)
            return ex_src.data;         // Distance 1
        if (wb_src.valid && wb_src.wen && wb_src.waddr == addr)
            return wb_src.data;         // Distance 2
        return rf_val;                  // Already in the file
    endfunction

    assign rs_fwd = pick_operand(rs, rf_rs, ex_fwd, retire);
    assign rt_fwd = pick_operand(rt, rf_rt, ex_fwd, retire);

    // ========================================================
    // Pipeline register
    // ========================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= inst_valid;
    end

    always_ff @(posedge clk) begin     // Payload, qualified by valid_q
        ctrl_q  <= ctrl;
        rs_q    <= rs_fwd;
        rt_q    <= rt_fwd;
        imm_q   <= inst[IMM_W-1:0];
        shamt_q <= inst[10:6];
    end

    assign id_ex = '{valid: valid_q, ctrl: ctrl_q, rs_val: rs_q, rt_val: rt_q,
                     imm: imm_q, shamt: shamt_q};

endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
// Execute stage
// Builds the ALU operands, runs the ALU, offers the live result as
// a bypass source and registers the retire record

`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  id_ex_t  id_ex,
    output fwd_t    ex_fwd,
    output retire_t retire
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_ovf;

    // SLL shifts rt, everything else starts from rs
    assign op_a = (id_ex.ctrl.opb_sel == OPB_SHAMT) ? id_ex.rt_val : id_ex.rs_val;

    always_comb begin
        case (id_ex.ctrl.opb_sel)
            OPB_SIMM:  op_b = {{(XLEN-IMM_W){id_ex.imm[IMM_W-1]}}, id_ex.imm};
            OPB_ZIMM:  op_b = {{(XLEN-IMM_W){1'b0}}, id_ex.imm};
            OPB_SHAMT: op_b = {{(XLEN-REG_ADDR_W){1'b0}}, id_ex.shamt};
            default:   op_b = id_ex.rt_val;
        endcase
    end

    alu u_alu (
        .op       (id_ex.ctrl.alu_op),
        .a        (op_a),
        .b        (op_b),
        .result   (alu_result),
        .overflow (alu_ovf)
    );

    // Live bypass for the instruction now in decode
    assign ex_fwd = '{wen:   id_ex.valid & id_ex.ctrl.wen,
                      waddr: id_ex.ctrl.waddr,
                      data:  alu_result};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            retire <= '0;
        end else begin
            retire.valid    <= id_ex.valid;
            retire.wen      <= id_ex.valid & id_ex.ctrl.wen;
            retire.waddr    <= id_ex.ctrl.waddr;
            retire.data     <= id_ex.ctrl.wen ? alu_result : '0;  // No-ops retire zero
            retire.overflow <= id_ex.valid & id_ex.ctrl.chk_ovf & alu_ovf;
            retire.syscall  <= id_ex.valid & id_ex.ctrl.syscall;
        end
    end

endmodule

`default_nettype wire

// ==== source/inst_decoder.sv ====
// Instruction decoder
// Turns one 32-bit instruction into the control record of the
// execute stage. Unknown encodings and writes to r0 come out with
// the write enable already cleared

`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import cpu_pkg::*;
(
    input  logic [XLEN-1:0] inst,
    output ctrl_t           ctrl
);

    opcode_e                opcode;
    funct_e                 funct;
    logic [REG_ADDR_W-1:0]  rt;
    logic [REG_ADDR_W-1:0]  rd;

    // Field split
    assign opcode = opcode_e'(inst[31:26]);
    assign funct  = funct_e'(inst[5:0]);
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];

    always_comb begin
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.opb_sel = OPB_REG;

        case (opcode)
            OP_RTYPE: begin
                ctrl.waddr = rd;            // R-type writes rd
                case (funct)
                    FN_ADD: begin
                        ctrl.wen     = 1'b1;
                        ctrl.chk_ovf = 1'b1;
                    end
                    FN_SUB: begin
                        ctrl.alu_op  = ALU_SUB;
                        ctrl.wen     = 1'b1;
                        ctrl.chk_ovf = 1'b1;
                    end
                    FN_AND: begin
                        ctrl.alu_op = ALU_AND;
                        ctrl.wen    = 1'b1;
                    end
                    FN_OR: begin
                        ctrl.alu_op = ALU_OR;
                        ctrl.wen    = 1'b1;
                    end
                    FN_SLT: begin
                        ctrl.alu_op = ALU_SLT;
                        ctrl.wen    = 1'b1;
                    end
                    FN_SLL: begin
                        ctrl.alu_op  = ALU_SLL;
                        ctrl.opb_sel = OPB_SHAMT;   // rt goes to port a
                        ctrl.wen     = 1'b1;
                    end
                    FN_SYSCALL: ctrl.syscall = 1'b1;
                    default: ;                      // Unknown funct
                endcase
            end
            OP_ADDI: begin
                ctrl.opb_sel = OPB_SIMM;
                ctrl.waddr   = rt;
                ctrl.wen     = 1'b1;
                ctrl.chk_ovf = 1'b1;
            end
            OP_ANDI: begin
                ctrl.alu_op  = ALU_AND;
                ctrl.opb_sel = OPB_ZIMM;
                ctrl.waddr   = rt;
                ctrl.wen     = 1'b1;
            end
            OP_ORI: begin
                ctrl.alu_op  = ALU_OR;
                ctrl.opb_sel = OPB_ZIMM;
                ctrl.waddr   = rt;
                ctrl.wen     = 1'b1;
            end
            OP_LUI: begin
                ctrl.alu_op  = ALU_LUI;
                ctrl.opb_sel = OPB_ZIMM;
                ctrl.waddr   = rt;
                ctrl.wen     = 1'b1;
            end
            default: ;                              // Retires as a no-op
        endcase

        // r0 is never written
        if (ctrl.waddr == '0)
            ctrl.wen = 1'b0;
        if (!ctrl.wen)
            ctrl.waddr = '0;    // Keeps retire fields clean for no-ops
    end

endmodule

`default_nettype wire

// ==== source/pipeline_cpu.sv ====
// Pipelined CPU top
// Three stages, decode, execute and writeback. One instruction per
// strobe, each retiring two cycles after its strobe

`timescale 1ns/1ps
`default_nettype none

module pipeline_cpu
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_valid,
    input  logic [XLEN-1:0] inst,
    output retire_t         retire
);

    id_ex_t id_ex;
    fwd_t   ex_fwd;

    decode_stage u_decode (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ex_fwd     (ex_fwd),
        .retire     (retire),   // Writeback and second bypass source
        .id_ex      (id_ex)
    );

    execute_stage u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .ex_fwd (ex_fwd),
        .retire (retire)
    );

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
// Register file
// 31 general registers with two combinational read ports and one
// write port fed from the retire record. r0 always reads zero

`timescale 1ns/1ps
`default_nettype none

module register_file
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] raddr0,
    input  logic [REG_ADDR_W-1:0] raddr1,
    output logic [XLEN-1:0]       rdata0,
    output logic [XLEN-1:0]       rdata1,
    input  retire_t               wr
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];   // No storage for r0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr.valid && wr.wen) begin
            regs[wr.waddr] <= wr.data;
        end
    end

    // Plain reads with no bypass
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

`default_nettype wire

// ==== include/cpu_ref_model.svh ====
// CPU reference model
// Executes one instruction in order on a model register array and
// returns the retire record the pipeline should produce for it

`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

function automatic retire_t ref_execute(
    input logic [XLEN-1:0] inst,
    ref   logic [XLEN-1:0] regs [NUM_REGS]
);
    opcode_e         op;
    funct_e          fn;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] simm;
    retire_t         r;

    op   = opcode_e'(inst[31:26]);
    fn   = funct_e'(inst[5:0]);
    a    = regs[inst[25:21]];
    b    = regs[inst[20:16]];
    simm = {{(XLEN-IMM_W){inst[15]}}, inst[15:0]};
    r       = '0;
    r.valid = 1'b1;

    case (op)
        OP_RTYPE: begin
            r.waddr = inst[15:11];
            r.wen   = fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLL};
            case (fn)
                FN_ADD: begin
                    r.data     = a + b;
                    r.overflow = (a[31] == b[31]) && (r.data[31] != a[31]);
                end
                FN_SUB: begin
                    r.data     = a - b;
                    r.overflow = (a[31] != b[31]) && (r.data[31] != a[31]);
                end
                FN_AND:     r.data = a & b;
                FN_OR:      r.data = a | b;
                FN_SLT:     r.data = ($signed(a) < $signed(b)) ? 1 : 0;
                FN_SLL:     r.data = b << inst[10:6];
                FN_SYSCALL: r.syscall = 1'b1;
                default: ;
            endcase
        end
        OP_ADDI: begin
            r.data     = a + simm;
            r.overflow = (a[31] == simm[31]) && (r.data[31] != a[31]);
            r.wen      = 1'b1;
        end
        OP_ANDI: begin
            r.data = a & {16'h0, inst[15:0]};
            r.wen  = 1'b1;
        end
        OP_ORI: begin
            r.data = a | {16'h0, inst[15:0]};
            r.wen  = 1'b1;
        end
        OP_LUI: begin
            r.data = {inst[15:0], 16'h0};
            r.wen  = 1'b1;
        end
        default: ;
    endcase
    if (op != OP_RTYPE)
        r.waddr = inst[20:16];     // I-type destination

    // r0 writes and no-ops retire with clean fields
    if (r.waddr == '0)
        r.wen = 1'b0;
    if (!r.wen) begin
        r.waddr = '0;
        r.data  = '0;
    end else begin
        regs[r.waddr] = r.data;
    end
    return r;
endfunction

`endif

// ==== test/cpu_tb.sv ====
// CPU testbench
// Acts as the fetch unit for the three-stage pipeline, runs directed
// and random programs and checks each retirement against an in-order
// reference model, including its exact retire cycle

`timescale 1ns/1ps
`default_nettype none

module cpu_tb
    import cpu_pkg::*;
;

    `include "cpu_ref_model.svh"

    logic            clk;
    logic            rst;
    logic            inst_valid;
    logic [XLEN-1:0] inst;
    retire_t         retire;

    logic [XLEN-1:0] model_regs [NUM_REGS];     // In-order architectural state
    retire_t         exp_q [$];                 // Expected retirements in issue order
    int              cycle_q [$];               // Cycle each one must retire in
    retire_t         exp_ret;
    int              exp_cycle;
    int              cycle = 0;
    int              errors = 0;
    int              checks = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;
    int              test_errors;
    string           test_name;

    pipeline_cpu dut (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .retire     (retire)
    );

    always #50 clk = ~clk;                      // 100 ns period

    always @(posedge clk)
        cycle <= cycle + 1;

    // ============================================================
    // Instruction encoding
    // ============================================================
    function automatic logic [XLEN-1:0] rtype_inst(funct_e fn, int rs, int rt, int rd, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic logic [XLEN-1:0] itype_inst(opcode_e op, int rs, int rt,
                                                   logic [IMM_W-1:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic report_mismatch(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
        $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        errors++;
    endtask

    task automatic check_write(retire_t act, retire_t exp);
        checks++;
        if (act.wen !== exp.wen)
            report_mismatch("retire.wen", XLEN'(act.wen), XLEN'(exp.wen));
        if (act.waddr !== exp.waddr)
            report_mismatch("retire.waddr", XLEN'(act.waddr), XLEN'(exp.waddr));
        if (act.data !== exp.data)
            report_mismatch("retire.data", act.data, exp.data);
    endtask

    task automatic check_event(retire_t act, retire_t exp);
        checks++;
        if (act.overflow !== exp.overflow)
            report_mismatch("retire.overflow", XLEN'(act.overflow), XLEN'(exp.overflow));
        if (act.syscall !== exp.syscall)
            report_mismatch("retire.syscall", XLEN'(act.syscall), XLEN'(exp.syscall));
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst && retire.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: instruction retired with none outstanding", $time);
                errors++;
            end else begin
                exp_ret   = exp_q.pop_front();
                exp_cycle = cycle_q.pop_front();
                if (cycle != exp_cycle) begin
                    $display("ERROR at %0t: retired in cycle %0d instead of cycle %0d",
                             $time, cycle, exp_cycle);
                    errors++;
                end
                check_write(retire, exp_ret);
                check_event(retire, exp_ret);
            end
        end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic strobe(logic [XLEN-1:0] word);
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = word;
        exp_q.push_back(ref_execute(word, model_regs));
        cycle_q.push_back(cycle + 2);           // Fixed two-cycle latency
    endtask

    task automatic gap(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            inst_valid = 1'b0;
            inst       = $urandom;              // Junk must be ignored
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        gap(1);
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR at %0t: no retirement arrived within 20 cycles, %0d outstanding",
                     $time, exp_q.size());
            errors++;
            exp_q.delete();
            cycle_q.delete();
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        drain();
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %-22s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-22s FAILED with %0d errors", test_name, errors - test_errors);
        end
    endtask

    function automatic logic [XLEN-1:0] random_inst();
        int unsigned     kind;
        int              rs;
        int              rt;
        int              rd;
        logic [IMM_W-1:0] imm;
        kind = $urandom_range(0, 10);
        rs   = $urandom_range(0, 15);           // Narrow range for more hazards
        rt   = $urandom_range(0, 15);
        rd   = $urandom_range(0, 15);
        imm  = IMM_W'($urandom);
        case (kind)
            0: return rtype_inst(FN_ADD, rs, rt, rd, 0);
            1: return rtype_inst(FN_SUB, rs, rt, rd, 0);
            2: return rtype_inst(FN_AND, rs, rt, rd, 0);
            3: return rtype_inst(FN_OR, rs, rt, rd, 0);
            4: return rtype_inst(FN_SLT, rs, rt, rd, 0);
            5: return rtype_inst(FN_SLL, 0, rt, rd, $urandom_range(0, 31));
            6: return rtype_inst(FN_SYSCALL, 0, 0, 0, 0);
            7: return itype_inst(OP_ADDI, rs, rt, imm);
            8: return itype_inst(OP_ANDI, rs, rt, imm);
            9: return itype_inst(OP_ORI, rs, rt, imm);
            default: return itype_inst(OP_LUI, 0, rt, imm);
        endcase
    endfunction

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        void'($urandom(72));
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;

        start_test("reset state");
        repeat (6) begin
            @(negedge clk);
            if (retire.valid !== 1'b0 || retire.wen !== 1'b0 ||
                retire.overflow !== 1'b0 || retire.syscall !== 1'b0) begin
                $display("ERROR at %0t: retire port active with no instruction issued", $time);
                errors++;
            end
        end
        for (int k = 1; k < NUM_REGS; k++)
            strobe(rtype_inst(FN_OR, 1, k, 1, 0));     // r1 |= rk over zeroed registers
        finish_test();

        start_test("isolated ops");
        strobe(itype_inst(OP_LUI, 0, 2, 16'h8001));
        drain();
        strobe(itype_inst(OP_ORI, 2, 3, 16'h1234));
        drain();
        strobe(itype_inst(OP_ANDI, 3, 4, 16'hF0F0));
        drain();
        strobe(itype_inst(OP_ADDI, 4, 5, 16'hFFFB));    // Negative immediate
        drain();
        strobe(rtype_inst(FN_AND, 3, 5, 6, 0));
        drain();
        strobe(rtype_inst(FN_OR, 2, 4, 7, 0));
        drain();
        strobe(rtype_inst(FN_SLT, 2, 4, 8, 0));         // Negative below positive
        drain();
        strobe(rtype_inst(FN_SLT, 4, 2, 9, 0));
        drain();
        strobe(rtype_inst(FN_SLL, 0, 3, 10, 7));
        finish_test();

        start_test("dependency chains");
        for (int d = 1; d <= 3; d++) begin
            for (int i = 0; i < 8; i++) begin
                case (i % 4)
                    0: strobe(itype_inst(OP_ADDI, (i >= d) ? 16 + i - d : 0, 16 + i,
                                         IMM_W'(16'h0111 * (i + d))));
                    1: strobe(rtype_inst(FN_ADD, 16 + i - d, 16 + i - d, 16 + i, 0));
                    2: strobe(rtype_inst(FN_SLL, 0, 16 + i - d, 16 + i, 3));
                    default: strobe(rtype_inst(FN_SUB, 5, 16 + i - d, 16 + i, 0));
                endcase
            end
            drain();
        end
        finish_test();

        start_test("overflow");
        strobe(itype_inst(OP_LUI, 0, 20, 16'h7FFF));
        strobe(itype_inst(OP_ORI, 20, 20, 16'hFFFF));  // Most positive
        strobe(itype_inst(OP_LUI, 0, 21, 16'h8000));   // Most negative
        strobe(itype_inst(OP_ADDI, 0, 22, 16'h0001));
        strobe(rtype_inst(FN_ADD, 20, 22, 23, 0));     // Wraps
        strobe(rtype_inst(FN_SUB, 21, 22, 24, 0));     // Wraps
        strobe(itype_inst(OP_ADDI, 20, 25, 16'h0001));
        strobe(itype_inst(OP_ADDI, 21, 26, 16'hFFFF));
        strobe(rtype_inst(FN_SUB, 20, 21, 29, 0));
        strobe(rtype_inst(FN_ADD, 20, 21, 27, 0));     // Mixed signs never overflow
        strobe(itype_inst(OP_ORI, 20, 28, 16'h0001));
        finish_test();

        start_test("no-write cases");
        strobe(rtype_inst(FN_SYSCALL, 0, 0, 0, 0));
        strobe(itype_inst(OP_ADDI, 0, 0, 16'h0037));   // r0 destination
        strobe(rtype_inst(FN_OR, 20, 21, 0, 0));
        strobe(itype_inst(opcode_e'(6'h3F), 3, 5, 16'h1234));  // Unknown opcode
        strobe(rtype_inst(funct_e'(6'h3E), 3, 4, 6, 0));       // Unknown funct
        strobe(rtype_inst(FN_OR, 0, 0, 30, 0));        // r0 still zero
        finish_test();

        start_test("random program");
        for (int n = 0; n < 300; n++) begin
            strobe(random_inst());
            if ($urandom_range(0, 2) == 0)
                gap($urandom_range(1, 3));
        end
        finish_test();

        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/cpu_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_cpu.sv
test/cpu_tb.sv
